// File: design/atom_bus_pkg.sv
`default_nettype none

// Processor bus widths and the Atom address map
package atom_bus_pkg;

   // ==================================================
   // Bus widths
   // ==================================================

   // Processor address and data byte
   typedef logic [15:0] addr_t;
   typedef logic [7:0]  data_t;

   // External SRAM address, 256K x 8
   typedef logic [17:0] ram_addr_t;

   // PIA register select, address bits 1:0
   typedef logic [1:0]  pia_reg_t;

   // ==================================================
   // Address map
   // ==================================================

   // ROM at C000-FFFF, address bits 15:14
   localparam logic [1:0] ROM_TOP  = 2'b11;

   // 1K pages, address bits 15:10
   // PIA at B000-B3FF
   localparam logic [5:0] PIA_PAGE = 6'b101100;
   // PL8 at B400-B7FF
   localparam logic [5:0] PL8_PAGE = 6'b101101;
   // VIA at B800-BBFF
   localparam logic [5:0] VIA_PAGE = 6'b101110;

   // SD card page BCxx, address bits 15:8, answered in the VIA row
   localparam logic [7:0] SPI_PAGE = 8'hBC;

   // Video RAM at 8000-9FFF, address bits 15:13
   localparam logic [2:0] VID_TOP  = 3'b100;

   // Lower 32K of RAM, address bit 15
   localparam logic       RAM_LOW  = 1'b0;

   // Unused space reads back the high address byte with these bits
   // Bus capacitance and pull downs on the real board
   localparam logic [7:0] FLOAT_MASK = 8'hF1;

endpackage

`default_nettype wire

// File: design/atom_timing_pkg.sv
`default_nettype none

// Clock divider, turbo and cassette timing
package atom_timing_pkg;

   // ==================================================
   // Processor clock
   // ==================================================

   // Speed select, 00 = 1 MHz, 01 = 2, 10 = 4, 11 = 8
   typedef logic [1:0] turbo_t;

   // Divider count over a 25-cycle window of clk25
   typedef logic [4:0] clkdiv_t;
   localparam clkdiv_t CLKDIV_LAST = 5'd24;

   // ==================================================
   // Cassette tone
   // ==================================================

   // Half period in processor enables
   // 208 = 16 * 13, close to the original 4 MHz / 16 / 13 / 8 chain
   localparam int CAS_HALF_PERIOD_DEFAULT = 208;
   typedef logic [7:0] cas_div_t;

endpackage

`default_nettype wire

// File: design/cpu_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

// Captured processor bus shared by the glue blocks
interface cpu_bus_if;
   import atom_bus_pkg::*;

   // Captured core outputs, held between enables
   addr_t address;
   data_t wdata;
   logic  rnw;

   // One-cycle processor clock enable
   logic  clken;

   // Capture register side
   modport source
   (
      output address, wdata, rnw,
      input  clken
   );

   // PIA side reads everything
   modport pia
   (
      input address, wdata, rnw, clken
   );

   // Enable generator side
   modport timing
   (
      output clken
   );

endinterface

`default_nettype wire

// File: design/clock_reset_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module clock_reset_ctrl
   (
      input  logic                    clk25,
      input  logic                    pwr_up_reset_n,
      input  atom_timing_pkg::turbo_t turbo,
      input  logic                    sw4,
      input  logic                    break_n,
      cpu_bus_if.timing               bus,
      output logic                    clken_d1,
      output logic                    system_reset
   );
   import atom_timing_pkg::*;

   clkdiv_t clkdiv;
   logic    en_hit;
   logic    clken_q;
   logic    hard_reset_n;

   // ==================================================
   // Enable pattern
   // ==================================================

   // Enables fall in the first 16 counts of the window
   // Counts 16-24 stay idle at every speed
   always_comb
   begin
      case (turbo)
         // 1 MHz, count 0 only
         2'b00: en_hit = (clkdiv == '0);
         // 2 MHz, counts 0 and 8
         2'b01: en_hit = (clkdiv[2:0] == 3'b000) && !clkdiv[4];
         // 4 MHz, every 4 counts
         2'b10: en_hit = (clkdiv[1:0] == 2'b00) && !clkdiv[4];
         // 8 MHz, every even count
         default: en_hit = !clkdiv[0] && !clkdiv[4];
      endcase
   end

   // ==================================================
   // Divider, enables and hard reset
   // ==================================================

   always_ff @(posedge clk25)
   begin
      if (!pwr_up_reset_n)
      begin
         clkdiv       <= '0;
         clken_q      <= 1'b0;
         clken_d1     <= 1'b0;
         hard_reset_n <= 1'b0;
      end
      else
      begin
         // Divide 25 MHz down to the window
         if (clkdiv == CLKDIV_LAST)
            clkdiv <= '0;
         else
            clkdiv <= clkdiv + 1'b1;
         // Registered, so one cycle behind the matching count
         clken_q  <= en_hit;
         // Write strobe slot
         clken_d1 <= clken_q;
         // Reset switch only sampled on processor cycles
         if (clken_q)
            hard_reset_n <= sw4;
      end
   end

   assign bus.clken = clken_q;

   // Break key acts at once
   assign system_reset = !hard_reset_n || !break_n;

endmodule

`default_nettype wire

// File: design/cassette_port.sv
`timescale 1ns/1ps
`default_nettype none

module cassette_port
   #(
      parameter int CAS_HALF_PERIOD = atom_timing_pkg::CAS_HALF_PERIOD_DEFAULT
   )
   (
      input  logic       clk25,
      input  logic       pwr_up_reset_n,
      cpu_bus_if.timing  bus,
      input  logic [2:0] pc_out,
      output logic       cas_tone,
      output logic       cas_out,
      output logic       sound
   );
   import atom_timing_pkg::*;

   // Last count before the tone flips
   localparam cas_div_t CAS_DIV_LAST = cas_div_t'(CAS_HALF_PERIOD - 1);

   cas_div_t cas_div;

   // ==================================================
   // Tone divider
   // ==================================================

   // Counts processor enables, so the pitch follows turbo
   always_ff @(posedge clk25)
   begin
      if (!pwr_up_reset_n)
      begin
         cas_div  <= '0;
         cas_tone <= 1'b0;
      end
      else if (bus.clken)
      begin
         if (cas_div == CAS_DIV_LAST)
         begin
            cas_div  <= '0;
            cas_tone <= !cas_tone;
         end
         else
            cas_div <= cas_div + 1'b1;
      end
   end

   // ==================================================
   // Output gating
   // ==================================================

   // Two NANDs and an inverter on the board
   // PC0 low parks the output high, PC1 lets the inverted tone through
   assign cas_out = !pc_out[0] || (pc_out[1] && !cas_tone);

   // Speaker bit
   assign sound = pc_out[2];

endmodule

`default_nettype wire

// File: design/pia_8255.sv
`timescale 1ns/1ps
`default_nettype none

module pia_8255
   (
      input  logic                clk25,
      input  logic                pwr_up_reset_n,
      cpu_bus_if.pia              bus,
      input  logic                pia_cs,
      input  logic [5:0]          key_cols,
      input  logic                shift_n,
      input  logic                ctrl_n,
      input  logic                rept_n,
      input  logic                cas_in,
      input  logic                fs_n,
      input  logic                cas_tone,
      output atom_bus_pkg::data_t port_a,
      output logic [3:0]          pc_out,
      output atom_bus_pkg::data_t pia_rdata
   );
   import atom_bus_pkg::*;

   // Port directions are fixed as the Atom uses them
   // A output, B input, C low nibble output, C high nibble input

   pia_reg_t reg_sel;
   logic     wr_en;

   assign reg_sel = bus.address[1:0];

   // Write on a processor cycle with the captured access
   assign wr_en = bus.clken && pia_cs && !bus.rnw;

   // ==================================================
   // Output registers
   // ==================================================

   always_ff @(posedge clk25)
   begin
      if (!pwr_up_reset_n)
      begin
         port_a <= '0;
         pc_out <= '0;
      end
      else if (wr_en)
      begin
         case (reg_sel)
            // Keyboard row and VDG mode
            2'd0: port_a <= bus.wdata;
            // Port C output nibble
            2'd2: pc_out <= bus.wdata[3:0];
            // Control word, bit set/reset when bit 7 is clear
            2'd3:
            begin
               if (!bus.wdata[7])
                  pc_out[bus.wdata[2:1]] <= bus.wdata[0];
            end
            // Port B is input only
            default: ;
         endcase
      end
   end

   // ==================================================
   // Read back
   // ==================================================

   always_comb
   begin
      case (reg_sel)
         2'd0: pia_rdata = port_a;
         // Modifier keys above the six key columns
         2'd1: pia_rdata = {shift_n, ctrl_n, key_cols};
         // Status inputs above the output nibble
         2'd2: pia_rdata = {fs_n, rept_n, cas_in, cas_tone, pc_out};
         // Control register is write only
         default: pia_rdata = '0;
      endcase
   end

endmodule

`default_nettype wire

// File: design/bus_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module bus_decoder
   (
      input  logic                    clk25,
      input  logic                    pwr_up_reset_n,
      input  atom_bus_pkg::addr_t     core_address,
      input  atom_bus_pkg::data_t     core_wdata,
      input  logic                    core_rnw,
      cpu_bus_if.source               bus,
      input  logic                    clken_d1,
      input  atom_bus_pkg::data_t     pia_rdata,
      input  atom_bus_pkg::data_t     ram_rdata,
      output logic                    pia_cs,
      output atom_bus_pkg::data_t     cpu_rdata,
      output atom_bus_pkg::ram_addr_t ram_addr,
      output atom_bus_pkg::data_t     ram_wdata,
      output logic                    ram_cs_n,
      output logic                    ram_oe_n,
      output logic                    ram_we_n
   );
   import atom_bus_pkg::*;

   logic rom_cs;
   logic pl8_cs;
   logic via_cs;
   logic vid_cs;
   logic ram_cs;

   // ==================================================
   // Bus capture
   // ==================================================

   // The core outputs are only valid on the enable edge
   always_ff @(posedge clk25)
   begin
      if (bus.clken)
      begin
         bus.address <= core_address;
         bus.wdata   <= core_wdata;
      end
   end

   // Direction starts as a read
   always_ff @(posedge clk25)
   begin
      if (!pwr_up_reset_n)
         bus.rnw <= 1'b1;
      else if (bus.clken)
         bus.rnw <= core_rnw;
   end

   // ==================================================
   // Chip selects
   // ==================================================

   assign rom_cs = (bus.address[15:14] == ROM_TOP);
   assign pia_cs = (bus.address[15:10] == PIA_PAGE);
   assign pl8_cs = (bus.address[15:10] == PL8_PAGE);
   // VIA row also answers the SD card page
   assign via_cs = (bus.address[15:10] == VIA_PAGE) || (bus.address[15:8] == SPI_PAGE);
   assign vid_cs = (bus.address[15:13] == VID_TOP);
   // ROM is a shadow in the external RAM
   assign ram_cs = (bus.address[15] == RAM_LOW) || rom_cs;

   // ==================================================
   // Read data
   // ==================================================

   // Priority order as on the board
   always_comb
   begin
      if (ram_cs)
         cpu_rdata = ram_rdata;
      else if (vid_cs)
         // no video RAM fitted
         cpu_rdata = '0;
      else if (pia_cs)
         cpu_rdata = pia_rdata;
      else if (pl8_cs)
         cpu_rdata = '0;
      else if (via_cs)
         cpu_rdata = '0;
      else
         // Floating bus
         cpu_rdata = bus.address[15:8] & FLOAT_MASK;
   end

   // ==================================================
   // External RAM strobes
   // ==================================================

   assign ram_addr  = {2'b00, bus.address};
   assign ram_wdata = bus.wdata;
   assign ram_cs_n  = 1'b0;
   assign ram_oe_n  = !bus.rnw;

   // One-cycle strobe in the cycle after capture
   // Writes to ROM space never reach the RAM
   assign ram_we_n = !(clken_d1 && !bus.rnw && !rom_cs);

endmodule

`default_nettype wire

// File: design/atom_glue.sv
`timescale 1ns/1ps
`default_nettype none

module atom_glue
   #(
      parameter int CAS_HALF_PERIOD = atom_timing_pkg::CAS_HALF_PERIOD_DEFAULT
   )
   (
      input  logic                    clk25,
      input  logic                    pwr_up_reset_n,
      input  atom_timing_pkg::turbo_t turbo,
      input  logic                    sw4,
      input  logic                    break_n,
      // Raw 6502 core bus
      input  atom_bus_pkg::addr_t     core_address,
      input  atom_bus_pkg::data_t     core_wdata,
      input  logic                    core_rnw,
      // Keyboard and VDG inputs
      input  logic [5:0]              key_cols,
      input  logic                    shift_n,
      input  logic                    ctrl_n,
      input  logic                    rept_n,
      input  logic                    cas_in,
      input  logic                    fs_n,
      input  atom_bus_pkg::data_t     ram_rdata,
      // Processor side
      output logic                    cpu_clken,
      output logic                    system_reset,
      output atom_bus_pkg::data_t     cpu_rdata,
      // PIA outputs
      output logic [3:0]              kbd_row,
      output logic [3:0]              vdg_mode,
      output logic                    css,
      output logic                    cas_out,
      output logic                    sound,
      // External SRAM
      output atom_bus_pkg::ram_addr_t ram_addr,
      output atom_bus_pkg::data_t     ram_wdata,
      output logic                    ram_cs_n,
      output logic                    ram_oe_n,
      output logic                    ram_we_n
   );
   import atom_bus_pkg::*;

   cpu_bus_if bus_if ();

   logic       clken_d1;
   logic       pia_cs;
   data_t      pia_rdata;
   data_t      port_a;
   logic [3:0] pia_pc;
   logic       cas_tone;

   // Port A low nibble scans the keyboard, high nibble sets VDG mode
   assign kbd_row   = port_a[3:0];
   assign vdg_mode  = port_a[7:4];
   // PC3 picks the alternate colour set
   assign css       = pia_pc[3];
   assign cpu_clken = bus_if.clken;

   // ==================================================
   // Blocks
   // ==================================================

   clock_reset_ctrl u_clock_reset_ctrl
   (
      .clk25          (clk25),
      .pwr_up_reset_n (pwr_up_reset_n),
      .turbo          (turbo),
      .sw4            (sw4),
      .break_n        (break_n),
      .bus            (bus_if.timing),
      .clken_d1       (clken_d1),
      .system_reset   (system_reset)
   );

   bus_decoder u_bus_decoder
   (
      .clk25          (clk25),
      .pwr_up_reset_n (pwr_up_reset_n),
      .core_address   (core_address),
      .core_wdata     (core_wdata),
      .core_rnw       (core_rnw),
      .bus            (bus_if.source),
      .clken_d1       (clken_d1),
      .pia_rdata      (pia_rdata),
      .ram_rdata      (ram_rdata),
      .pia_cs         (pia_cs),
      .cpu_rdata      (cpu_rdata),
      .ram_addr       (ram_addr),
      .ram_wdata      (ram_wdata),
      .ram_cs_n       (ram_cs_n),
      .ram_oe_n       (ram_oe_n),
      .ram_we_n       (ram_we_n)
   );

   pia_8255 u_pia_8255
   (
      .clk25          (clk25),
      .pwr_up_reset_n (pwr_up_reset_n),
      .bus            (bus_if.pia),
      .pia_cs         (pia_cs),
      .key_cols       (key_cols),
      .shift_n        (shift_n),
      .ctrl_n         (ctrl_n),
      .rept_n         (rept_n),
      .cas_in         (cas_in),
      .fs_n           (fs_n),
      .cas_tone       (cas_tone),
      .port_a         (port_a),
      .pc_out         (pia_pc),
      .pia_rdata      (pia_rdata)
   );

   cassette_port #(
      .CAS_HALF_PERIOD (CAS_HALF_PERIOD)
   ) u_cassette_port
   (
      .clk25          (clk25),
      .pwr_up_reset_n (pwr_up_reset_n),
      .bus            (bus_if.timing),
      .pc_out         (pia_pc[2:0]),
      .cas_tone       (cas_tone),
      .cas_out        (cas_out),
      .sound          (sound)
   );

endmodule

`default_nettype wire

// File: dv/tb_atom_glue.sv
`timescale 1ns/1ps
`default_nettype none

module tb_atom_glue;
   import atom_bus_pkg::*;
   import atom_timing_pkg::*;

   // Short tone half period keeps the cassette test brief
   localparam int          CAS_HP = 10;
   localparam logic [31:0] SEED   = 32'h3d74_0586;

   logic       clk25;
   logic       pwr_up_reset_n;
   turbo_t     turbo;
   logic       sw4;
   logic       break_n;
   addr_t      core_address;
   data_t      core_wdata;
   logic       core_rnw;
   logic [5:0] key_cols;
   logic       shift_n;
   logic       ctrl_n;
   logic       rept_n;
   logic       cas_in;
   logic       fs_n;
   data_t      ram_rdata;
   logic       cpu_clken;
   logic       system_reset;
   data_t      cpu_rdata;
   logic [3:0] kbd_row;
   logic [3:0] vdg_mode;
   logic       css;
   logic       cas_out;
   logic       sound;
   ram_addr_t  ram_addr;
   data_t      ram_wdata;
   logic       ram_cs_n;
   logic       ram_oe_n;
   logic       ram_we_n;

   // Trace commands
   string op_q[$];
   addr_t addr_q[$];
   data_t data_q[$];
   data_t exp_q[$];

   // Expected PIA state and enable count since reset
   data_t       port_a_m;
   logic [3:0]  pc_m;
   int          en_count = 0;
   logic [31:0] rnd;

   int cycle_count = 0;
   int cycle_limit = 0;
   int errors      = 0;
   int checks      = 0;
   int test_errors = 0;
   int test_checks = 0;
   int cur_test    = 0;
   int tests_done  = 0;

   atom_glue #(.CAS_HALF_PERIOD(CAS_HP)) dut (.*);

   // ==================================================
   // Clock, timeout and enable monitor
   // ==================================================

   always #50 clk25 = !clk25;

   always @(posedge clk25)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_limit > 0 && cycle_count > cycle_limit)
      begin
         $display("Timeout: the trace did not finish within %0d cycles", cycle_limit);
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   // Tone divider advances on each enable edge
   always @(posedge clk25)
   begin
      if (!pwr_up_reset_n)
         en_count <= 0;
      else if (cpu_clken)
         en_count <= en_count + 1;
   end

   // ==================================================
   // Helpers
   // ==================================================

   function automatic logic [31:0] next_random(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Register read values by the 8255 packing rule
   function automatic data_t expected_pia(input pia_reg_t r);
      logic tone;
      tone = ((en_count / CAS_HP) % 2) == 1;
      case (r)
         2'd0: return port_a_m;
         2'd1: return {shift_n, ctrl_n, key_cols};
         2'd2: return {fs_n, rept_n, cas_in, tone, pc_m};
         default: return '0;
      endcase
   endfunction

   // Inputs change 1 ns after the rising edge
   task automatic tick();
      @(posedge clk25);
      #1;
   endtask

   // High at edge plus 1 ns means the coming edge is an enable
   task automatic wait_clken();
      while (!cpu_clken)
         tick();
   endtask

   task automatic check_data(input string name, input data_t got, input data_t exp);
      checks++;
      test_checks++;
      if (got !== exp)
      begin
         errors++;
         test_errors++;
         $display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_addr(input string name, input ram_addr_t got, input ram_addr_t exp);
      checks++;
      test_checks++;
      if (got !== exp)
      begin
         errors++;
         test_errors++;
         $display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      checks++;
      test_checks++;
      if (got !== exp)
      begin
         errors++;
         test_errors++;
         $display("FAILED at %0t: %s = %b, expected %b", $time, name, got, exp);
      end
   endtask

   // ==================================================
   // Operations
   // ==================================================

   task automatic power_up_reset(input logic exp_sr);
      pwr_up_reset_n = 1'b0;
      repeat (5)
      begin
         tick();
         check_bit("system_reset", system_reset, exp_sr);
         check_bit("ram_we_n", ram_we_n, 1'b1);
      end
      pwr_up_reset_n = 1'b1;
      port_a_m = '0;
      pc_m     = '0;
      tick();
      check_data("kbd_row", {4'h0, kbd_row}, 8'h00);
      check_data("vdg_mode", {4'h0, vdg_mode}, 8'h00);
      check_bit("css", css, 1'b0);
      check_bit("sound", sound, 1'b0);
      // Tone low and PC0 clear park the cassette line high
      check_bit("cas_out", cas_out, 1'b1);
      // Hard reset clears on the first enable
      wait_clken();
      tick();
      check_bit("system_reset", system_reset, 1'b0);
   endtask

   task automatic count_rate(input turbo_t t, input data_t exp);
      int n;
      turbo = t;
      tick();
      n = 0;
      // Ten windows of 25 cycles
      repeat (250)
      begin
         if (cpu_clken)
            n++;
         tick();
      end
      check_data("cpu_clken_count", data_t'(n), exp);
   endtask

   task automatic bus_read(input addr_t a, input data_t rd, input data_t exp,
                           input logic from_model);
      data_t want;
      wait_clken();
      core_address = a;
      core_rnw     = 1'b1;
      ram_rdata    = rd;
      tick();
      want = from_model ? expected_pia(a[1:0]) : exp;
      check_data("cpu_rdata", cpu_rdata, want);
      check_addr("ram_addr", ram_addr, {2'b00, a});
      check_bit("ram_oe_n", ram_oe_n, 1'b0);
      check_bit("ram_cs_n", ram_cs_n, 1'b0);
   endtask

   task automatic bus_write(input addr_t a, input data_t d, input logic exp_we);
      wait_clken();
      core_address = a;
      core_wdata   = d;
      core_rnw     = 1'b0;
      tick();
      // Cycle right after capture carries the strobe
      check_addr("ram_addr", ram_addr, {2'b00, a});
      check_data("ram_wdata", ram_wdata, d);
      check_bit("ram_oe_n", ram_oe_n, 1'b1);
      check_bit("ram_we_n", ram_we_n, !exp_we);
      tick();
      check_bit("ram_we_n", ram_we_n, 1'b1);
      while (!cpu_clken)
      begin
         tick();
         check_bit("ram_we_n", ram_we_n, 1'b1);
      end
      // Back to a read; PIA register loads on this enable
      core_rnw = 1'b1;
      tick();
      if (a[15:10] == 6'b101100)
      begin
         case (a[1:0])
            2'd0: port_a_m = d;
            2'd2: pc_m = d[3:0];
            2'd3:
            begin
               if (!d[7])
                  pc_m[d[2:1]] = d[0];
            end
            default: ;
         endcase
      end
      check_data("kbd_row", {4'h0, kbd_row}, {4'h0, port_a_m[3:0]});
      check_data("vdg_mode", {4'h0, vdg_mode}, {4'h0, port_a_m[7:4]});
      check_bit("css", css, pc_m[3]);
      check_bit("sound", sound, pc_m[2]);
   endtask

   task automatic randomize_inputs();
      rnd      = next_random(rnd);
      key_cols = rnd[5:0];
      shift_n  = rnd[8];
      ctrl_n   = rnd[9];
      rept_n   = rnd[10];
      cas_in   = rnd[11];
      fs_n     = rnd[12];
   endtask

   // Enables between two cas_out edges
   task automatic measure_tone(input data_t exp);
      logic last;
      int   n;
      last = cas_out;
      while (cas_out == last)
         tick();
      last = cas_out;
      n    = 0;
      while (cas_out == last)
      begin
         if (cpu_clken)
            n++;
         tick();
      end
      check_data("cas_out_period", data_t'(n), exp);
   endtask

   task automatic hold_cassette(input logic level);
      int   i;
      logic held;
      held = 1'b1;
      for (i = 0; i < 100 && held; i++)
      begin
         tick();
         if (cas_out !== level)
            held = 1'b0;
      end
      check_bit("cas_out", cas_out, level);
   endtask

   // ==================================================
   // Trace handling
   // ==================================================

   task automatic load_trace(output logic ok);
      int          fd;
      int          n;
      string       line;
      string       op;
      logic [31:0] ta;
      logic [31:0] td;
      logic [31:0] te;
      ok = 1'b0;
      fd = $fopen("dv/atom_glue_trace.txt", "r");
      if (fd == 0)
         $display("Could not open the trace file dv/atom_glue_trace.txt");
      else
      begin
         while (!$feof(fd))
         begin
            line = "";
            n    = $fgets(line, fd);
            // Hash lines hold column notes
            if (n > 0 && line.len() > 0 && line[0] != 8'h23)
            begin
               if ($sscanf(line, "%s %h %h %h", op, ta, td, te) == 4)
               begin
                  op_q.push_back(op);
                  addr_q.push_back(ta[15:0]);
                  data_q.push_back(td[7:0]);
                  exp_q.push_back(te[7:0]);
               end
            end
         end
         $fclose(fd);
         ok = (op_q.size() > 0);
         if (!ok)
            $display("The trace file holds no commands");
      end
   endtask

   task automatic report_test();
      if (cur_test > 0)
      begin
         $display("test %0d: %0d checks, %0d errors", cur_test, test_checks, test_errors);
         tests_done++;
      end
   endtask

   task automatic run_trace();
      int    i;
      string op;
      addr_t a;
      data_t d;
      data_t e;
      for (i = 0; i < op_q.size(); i++)
      begin
         op = op_q[i];
         a  = addr_q[i];
         d  = data_q[i];
         e  = exp_q[i];
         if (op == "tst")
         begin
            report_test();
            cur_test    = int'(a);
            test_checks = 0;
            test_errors = 0;
         end
         else if (op == "rate")
            count_rate(a[1:0], e);
         else if (op == "trb")
         begin
            turbo = a[1:0];
            tick();
         end
         else if (op == "rd")
            bus_read(a, d, e, 1'b0);
         else if (op == "pia")
            bus_read(a, d, e, 1'b1);
         else if (op == "wr")
            bus_write(a, d, e[0]);
         else if (op == "key")
            randomize_inputs();
         else if (op == "cas" && a[0])
            measure_tone(e);
         else if (op == "cas")
            hold_cassette(e[0]);
         else if (op == "rst")
            power_up_reset(e[0]);
         else if (op == "brk")
         begin
            // Break acts without waiting for an enable
            break_n = a[0];
            tick();
            check_bit("system_reset", system_reset, e[0]);
         end
         else if (op == "sw4")
         begin
            sw4 = a[0];
            wait_clken();
            tick();
            check_bit("system_reset", system_reset, e[0]);
         end
         else
         begin
            errors++;
            test_errors++;
            $display("Unknown trace opcode %s in command %0d", op, i);
         end
      end
      report_test();
   endtask

   // ==================================================
   // Main sequence
   // ==================================================

   initial
   begin
      logic ok;
      clk25          = 1'b0;
      pwr_up_reset_n = 1'b0;
      turbo          = 2'b00;
      sw4            = 1'b1;
      break_n        = 1'b1;
      core_address   = '0;
      core_wdata     = '0;
      core_rnw       = 1'b1;
      key_cols       = '0;
      shift_n        = 1'b1;
      ctrl_n         = 1'b1;
      rept_n         = 1'b1;
      cas_in         = 1'b0;
      fs_n           = 1'b1;
      ram_rdata      = '0;
      port_a_m       = '0;
      pc_m           = '0;
      rnd            = SEED;
      load_trace(ok);
      if (!ok)
      begin
         $display("*** TEST FAILED ***");
         $finish;
      end
      else
      begin
         cycle_limit = op_q.size() * 60 + 2000;
         power_up_reset(1'b1);
         run_trace();
         $display("summary: %0d tests, %0d checks, %0d errors", tests_done, checks, errors);
         if (errors == 0)
            $display("*** TEST PASSED ***");
         else
            $display("*** TEST FAILED ***");
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: dv/atom_glue_trace.txt
# columns: opcode, address (hex), data (hex), expected (hex)
# opcodes: tst rate trb rd pia wr key cas rst brk sw4
tst 1 0 0
rate 0 0 0a
rate 1 0 14
rate 2 0 28
rate 3 0 50
tst 2 0 0
wr b000 5a 01
wr b002 0f 01
pia b002 0 0
wr b003 06 01
wr b003 04 01
wr b003 80 01
pia b000 0 0
pia b002 0 0
pia b003 0 0
tst 3 0 0
key 0 0 0
pia b001 0 0
pia b002 0 0
key 0 0 0
pia b001 0 0
pia b002 0 0
tst 4 0 0
rd 1234 5a 5a
rd c123 a5 a5
rd 8100 77 00
rd b400 77 00
rd b800 77 00
rd bc20 77 00
rd a3c4 77 a1
wr 2345 c3 01
wr bc10 11 01
wr c000 3c 00
tst 5 0 0
trb 3 0 0
wr b002 03 01
cas 1 0 0a
wr b003 00 01
cas 0 0 01
tst 6 0 0
rst 0 0 01
brk 0 0 01
brk 1 0 00
sw4 0 0 01
sw4 1 0 00

// File: compile.f
design/atom_bus_pkg.sv
design/atom_timing_pkg.sv
design/cpu_bus_if.sv
design/clock_reset_ctrl.sv
design/cassette_port.sv
design/pia_8255.sv
design/bus_decoder.sv
design/atom_glue.sv
dv/tb_atom_glue.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the atom_glue testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
   echo "Cannot enter the project root"
   exit 1
fi

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps \
   --top-module tb_atom_glue -f compile.f \
   --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -F -q "*** TEST FAILED ***" "$LOG"; then
   exit 1
fi
exit 0
